/* all.f */
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_rangecheck.sv
verilog/lsu_agen.sv
verilog/lsu_access_window.sv
verilog/lsu_addrcheck.sv
verilog/lsu_addrcheck_top.sv
test/lsu_addrcheck_model.sv
test/tb_lsu_addrcheck.sv

/* test/tb_lsu_addrcheck.sv */
//**************************************************
// Random traffic on the address check with the default map
// mrac stays fixed for the whole run
//**************************************************
`include "lsu_memmap.svh"

module tb_lsu_addrcheck
   import lsu_addrcheck_model::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_requests = 4000;
   localparam int drain_limit  = 8;

   logic               clk, rst_n, lsu_valid, load, store, dma, fast_int;
   logic [31:0]        rs1, mrac;
   logic signed [11:0] offset;
   logic [1:0]         size;
   logic               addr_in_dccm_d, addr_in_pic_d, addr_external_d;
   logic               access_fault_d, misaligned_fault_d, is_sideeffects_m;
   logic               fir_dccm_access_error_d, fir_nondccm_access_error_d;
   logic [2:0]         exc_mscause_d;
   integer             seed;
   int                 errors, checks;
   expect_t            exp_q [$];    // D-stage results in request order
   logic               side_q [$];   // One stage further

   lsu_addrcheck_top uut (
      .lsu_c2_m_clk (clk), .rst_n (rst_n), .lsu_valid (lsu_valid), .rs1 (rs1),
      .offset (offset), .size (size), .load (load), .store (store), .dma (dma),
      .fast_int (fast_int), .mrac (mrac), .addr_in_dccm_d (addr_in_dccm_d),
      .addr_in_pic_d (addr_in_pic_d), .addr_external_d (addr_external_d),
      .access_fault_d (access_fault_d), .misaligned_fault_d (misaligned_fault_d),
      .exc_mscause_d (exc_mscause_d), .fir_dccm_access_error_d (fir_dccm_access_error_d),
      .fir_nondccm_access_error_d (fir_nondccm_access_error_d),
      .is_sideeffects_m (is_sideeffects_m)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic drive_idle();
      lsu_valid = 1'b0;
      rs1       = '0;
      offset    = '0;
      size      = 2'd0;
      {load, store, dma, fast_int} = 4'b0;
   endtask

   task automatic drive_request();
      logic [31:0] corner;

      offset = 12'($random(seed));
      case ({$random(seed)} % 8)
         0: rs1 = `LSU_DCCM_SADR + ({$random(seed)} % `LSU_DCCM_SIZE);
         1: rs1 = `LSU_PIC_SADR + ({$random(seed)} % `LSU_PIC_SIZE);
         2: begin                                      // Around the DCCM and PIC edges
            case ({$random(seed)} % 5)
               0: corner = `LSU_DCCM_SADR;
               1: corner = `LSU_DCCM_SADR + `LSU_DCCM_SIZE;
               2: corner = `LSU_PIC_SADR;
               3: corner = `LSU_PIC_SADR + `LSU_PIC_SIZE;
               default: corner = {4'hF, 28'($random(seed))};
            endcase
            rs1    = corner - 32'({$random(seed)} % 4);
            offset = 12'($random(seed) % 8);
         end
         3: rs1 = {`LSU_ICCM_REGION, 28'($random(seed))};
         4: rs1 = {4'h0, 28'($random(seed))};                    // Window 0
         5: rs1 = `LSU_WIN1_ADDR + ({$random(seed)} % 32'h0010_0400);
         6: begin                                      // Either side of a region boundary
            rs1    = {4'($random(seed)), 28'h0} + 32'($random(seed) % 8);
            offset = 12'($random(seed) % 16);
         end
         default: rs1 = $random(seed);
      endcase
      size      = 2'({$random(seed)} % 3);
      lsu_valid = ({$random(seed)} % 8) != 0;
      load      = 1'($random(seed));
      store     = !load && 1'($random(seed));
      dma       = ({$random(seed)} % 8) == 0;
      fast_int  = ({$random(seed)} % 6) == 0;
      exp_q.push_back(predict(lsu_valid, rs1, offset, size, load, store, dma, fast_int, mrac));
   endtask

   task automatic check_quiet();
      checks++;
      assert (!(access_fault_d | misaligned_fault_d | fir_dccm_access_error_d |
                fir_nondccm_access_error_d | is_sideeffects_m)) else begin
         errors++;
         $display("FAIL %0t: fault or side-effect output active during reset", $time);
      end
   endtask

   task automatic check_outputs();
      expect_t want, got;
      logic    side_want;

      if (side_q.size() > 0) begin
         side_want = side_q.pop_front();
         checks++;
         assert (is_sideeffects_m === side_want) else begin
            errors++;
            $display("FAIL %0t: is_sideeffects_m is %b, expected %b",
                     $time, is_sideeffects_m, side_want);
         end
      end
      if (exp_q.size() > 0) begin
         want = exp_q.pop_front();
         got  = {addr_in_dccm_d, addr_in_pic_d, addr_external_d, access_fault_d,
                 misaligned_fault_d, exc_mscause_d, fir_dccm_access_error_d,
                 fir_nondccm_access_error_d, want.side};
         checks++;
         assert (got === want) else begin
            errors++;
            $display("FAIL %0t: dccm pic ext af mf cause fir_d fir_n = %b, expected %b",
                     $time, got[10:1], want[10:1]);
         end
         side_q.push_back(want.side);
      end
   endtask

   task automatic drain_queues();
      int waited;

      waited = 0;
      while ((exp_q.size() + side_q.size()) > 0 && waited < drain_limit) begin
         @(negedge clk);
         check_outputs();
         drive_idle();
         waited++;
      end
      if ((exp_q.size() + side_q.size()) > 0) begin
         errors++;
         $display("Timeout: results still pending after %0d idle cycles", waited);
      end
   endtask

   initial begin
      int n;

      seed   = 32'h4d25_7e8c;
      errors = 0;
      checks = 0;
      rst_n  = 1'b0;
      drive_idle();
      mrac     = $random(seed);
      mrac[1]  = 1'b1;   // Window 0 region has side effects
      mrac[21] = 1'b1;   // Window 1 region
      mrac[29] = 1'b1;   // ICCM region never has side effects here
      mrac[31] = 1'b1;
      // Unaligned fast-interrupt load in window 0 held through reset
      lsu_valid = 1'b1;
      rs1       = 32'h0000_0001;
      size      = 2'd2;
      load      = 1'b1;
      fast_int  = 1'b1;
      repeat (10) begin
         @(negedge clk);
         check_quiet();
      end
      drive_idle();
      rst_n = 1'b1;
      for (n = 0; n < num_requests; n++) begin
         @(negedge clk);
         check_outputs();
         drive_request();
      end
      drain_queues();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* test/lsu_addrcheck_model.sv */
//**************************************************
// Reference model of the address check rules
// Default memory map only, DCCM and PIC share one region
//**************************************************
package lsu_addrcheck_model;

`include "lsu_memmap.svh"

   typedef struct packed {
      logic       in_dccm;
      logic       in_pic;
      logic       external;
      logic       access_fault;
      logic       misaligned_fault;
      logic [2:0] mscause;
      logic       fir_dccm;
      logic       fir_nondccm;
      logic       side;              // Shows on is_sideeffects_m a cycle later
   } expect_t;

   localparam logic [31:0]      dccm_base = `LSU_DCCM_SADR;
   localparam logic [31:0]      pic_base  = `LSU_PIC_SADR;
   localparam logic [3:0]       win_en    = `LSU_WIN_ENABLE;
   localparam logic [3:0][31:0] win_addr  =
      {`LSU_WIN3_ADDR, `LSU_WIN2_ADDR, `LSU_WIN1_ADDR, `LSU_WIN0_ADDR};
   localparam logic [3:0][31:0] win_mask  =
      {`LSU_WIN3_MASK, `LSU_WIN2_MASK, `LSU_WIN1_MASK, `LSU_WIN0_MASK};

   // Base is aligned to its power of two size
   function automatic logic in_range(logic [31:0] addr, logic [31:0] base, logic [31:0] size);
      return (addr & ~(size - 32'd1)) == (base & ~(size - 32'd1));
   endfunction

   function automatic logic window_hit(logic [31:0] addr);
      logic hit;
      int   w;

      hit = 1'b0;
      for (w = 0; w < 4; w++) begin
         hit |= win_en[w] && ((addr | win_mask[w]) == (win_addr[w] | win_mask[w]));
      end
      return hit;
   endfunction

   function automatic expect_t predict(logic valid, logic [31:0] rs1, logic [11:0] offset,
                                       logic [1:0] size, logic load, logic store,
                                       logic dma, logic fast_int, logic [31:0] mrac);
      logic [31:0] start_a, end_a;
      logic        s_dccm, e_dccm, s_dccm_reg, e_dccm_reg, s_pic, e_pic, win_ok;
      logic        unmapped, mpu, regpred, picm, regcross, aligned, live;
      expect_t     e;

      start_a    = rs1 + {{20{offset[11]}}, offset};
      end_a      = start_a + ((size == 2'd2) ? 32'd3 : {31'd0, size == 2'd1});
      s_dccm     = in_range(start_a, dccm_base, `LSU_DCCM_SIZE);
      e_dccm     = in_range(end_a, dccm_base, `LSU_DCCM_SIZE);
      s_dccm_reg = start_a[31:28] == dccm_base[31:28];
      e_dccm_reg = end_a[31:28] == dccm_base[31:28];
      s_pic      = in_range(start_a, pic_base, `LSU_PIC_SIZE);
      e_pic      = in_range(end_a, pic_base, `LSU_PIC_SIZE);
      live       = valid && !dma;   // DMA never faults

      e.in_dccm  = s_dccm && e_dccm;
      e.in_pic   = s_pic && e_pic;
      e.external = !(s_dccm_reg || (start_a[31:28] == pic_base[31:28]));

      // No enabled window leaves external space open
      win_ok   = (win_en == 4'b0) || (window_hit(start_a) && window_hit(end_a));
      unmapped = (s_dccm_reg && !(s_dccm || s_pic)) || (e_dccm_reg && !(e_dccm || e_pic)) ||
                 (s_dccm && e_pic) || (s_pic && e_dccm);
      mpu      = !s_dccm_reg && !win_ok;
      regpred  = e.external == ((rs1[31:28] == `LSU_DCCM_REGION) ||
                                (rs1[31:28] == `LSU_PIC_REGION));
      picm     = e.in_pic && ((start_a[1:0] != 2'b00) || (size != 2'd2));
      e.access_fault = (unmapped || mpu || regpred || picm) && live;

      regcross = start_a[31:28] != end_a[31:28];
      aligned  = (size == 2'd0) || ((size == 2'd1) && !start_a[0]) ||
                 ((size == 2'd2) && (start_a[1:0] == 2'b00));
      e.side   = mrac[{start_a[31:28], 1'b1}] && e.external && (start_a[31:28] != 4'hE) &&
                 valid && (load || store);
      e.misaligned_fault = (regcross || (e.side && !aligned)) && live;

      if (e.misaligned_fault)  e.mscause = regcross ? 3'd0 : 3'd1;
      else if (unmapped)       e.mscause = 3'd0;
      else if (mpu)            e.mscause = 3'd3;
      else if (regpred)        e.mscause = 3'd5;
      else if (picm)           e.mscause = 3'd6;
      else                     e.mscause = 3'd7;

      e.fir_dccm    = ((s_dccm_reg && !s_dccm) || (e_dccm_reg && !e_dccm)) && valid && fast_int;
      e.fir_nondccm = !(s_dccm_reg && e_dccm_reg) && valid && fast_int;
      return e;
   endfunction

endpackage

/* verilog/lsu_addrcheck_top.sv */
//**************************************************
// Load/store address check, memory map set by parameters
// No back-pressure, a request may arrive every cycle
//**************************************************
module lsu_addrcheck_top
   import lsu_pkg::*;
#(
   parameter int                                 NUM_WINDOWS = num_windows_dflt,
   parameter logic [NUM_WINDOWS-1:0][addr_w-1:0] WIN_ADDR    = win_addr_dflt,
   parameter logic [NUM_WINDOWS-1:0][addr_w-1:0] WIN_MASK    = win_mask_dflt,
   parameter logic [NUM_WINDOWS-1:0]             WIN_ENABLE  = win_enable_dflt,
   parameter bit                                 DCCM_ENABLE = dccm_enable_dflt,
   parameter logic [addr_w-1:0]                  DCCM_SADR   = dccm_sadr_dflt,
   parameter int unsigned                        DCCM_SIZE   = dccm_size_dflt,
   parameter logic [region_w-1:0]                DCCM_REGION = dccm_region_dflt,
   parameter logic [addr_w-1:0]                  PIC_SADR    = pic_sadr_dflt,
   parameter int unsigned                        PIC_SIZE    = pic_size_dflt,
   parameter logic [region_w-1:0]                PIC_REGION  = pic_region_dflt,
   parameter bit                                 ICCM_ENABLE = iccm_enable_dflt,
   parameter logic [region_w-1:0]                ICCM_REGION = iccm_region_dflt
)(
   input  logic               lsu_c2_m_clk,
   input  logic               rst_n,
   input  logic               lsu_valid,
   input  logic [addr_w-1:0]  rs1,
   input  logic signed [11:0] offset,
   input  logic [1:0]         size,
   input  logic               load,
   input  logic               store,
   input  logic               dma,
   input  logic               fast_int,
   input  logic [31:0]        mrac,
   output logic               addr_in_dccm_d,
   output logic               addr_in_pic_d,
   output logic               addr_external_d,
   output logic               access_fault_d,
   output logic               misaligned_fault_d,
   output logic [2:0]         exc_mscause_d,
   output logic               fir_dccm_access_error_d,
   output logic               fir_nondccm_access_error_d,
   output logic               is_sideeffects_m
);

   logic [addr_w-1:0]      start_addr_d, end_addr_d;
   logic [region_w-1:0]    rs1_region_d;
   logic                   valid_d, load_d, store_d, dma_d, fast_int_d;
   logic [1:0]             size_d;
   logic [NUM_WINDOWS-1:0] win_start_hit, win_end_hit;

   lsu_agen agen (.*);

   for (genvar i = 0; i < NUM_WINDOWS; i++) begin : g_win
      lsu_access_window #(
         .WIN_ADDR   (WIN_ADDR[i]),
         .WIN_MASK   (WIN_MASK[i]),
         .WIN_ENABLE (WIN_ENABLE[i])
      ) window (
         .start_addr (start_addr_d),
         .end_addr   (end_addr_d),
         .start_hit  (win_start_hit[i]),
         .end_hit    (win_end_hit[i])
      );
   end

   lsu_addrcheck #(
      .DCCM_ENABLE (DCCM_ENABLE),
      .DCCM_SADR   (DCCM_SADR),
      .DCCM_SIZE   (DCCM_SIZE),
      .DCCM_REGION (DCCM_REGION),
      .PIC_SADR    (PIC_SADR),
      .PIC_SIZE    (PIC_SIZE),
      .PIC_REGION  (PIC_REGION),
      .ICCM_ENABLE (ICCM_ENABLE),
      .ICCM_REGION (ICCM_REGION),
      .NUM_WINDOWS (NUM_WINDOWS),
      .WIN_ENABLE  (WIN_ENABLE)
   ) addrcheck (.*);

endmodule

/* verilog/lsu_addrcheck.sv */
//**************************************************
// Memory map check, faults and mscause for the D stage
// ECC is not covered, mscause 1 comes from misalignment only
//**************************************************
module lsu_addrcheck
   import lsu_pkg::*;
#(
   parameter bit                     DCCM_ENABLE = dccm_enable_dflt,
   parameter logic [addr_w-1:0]      DCCM_SADR   = dccm_sadr_dflt,
   parameter int unsigned            DCCM_SIZE   = dccm_size_dflt,
   parameter logic [region_w-1:0]    DCCM_REGION = dccm_region_dflt,
   parameter logic [addr_w-1:0]      PIC_SADR    = pic_sadr_dflt,
   parameter int unsigned            PIC_SIZE    = pic_size_dflt,
   parameter logic [region_w-1:0]    PIC_REGION  = pic_region_dflt,
   parameter bit                     ICCM_ENABLE = iccm_enable_dflt,
   parameter logic [region_w-1:0]    ICCM_REGION = iccm_region_dflt,
   parameter int                     NUM_WINDOWS = num_windows_dflt,
   parameter logic [NUM_WINDOWS-1:0] WIN_ENABLE  = win_enable_dflt
)(
   input  logic                   lsu_c2_m_clk,
   input  logic                   rst_n,
   input  logic [addr_w-1:0]      start_addr_d,
   input  logic [addr_w-1:0]      end_addr_d,
   input  logic [region_w-1:0]    rs1_region_d,
   input  logic                   valid_d,
   input  logic [1:0]             size_d,
   input  logic                   load_d,
   input  logic                   store_d,
   input  logic                   dma_d,
   input  logic                   fast_int_d,
   input  logic [NUM_WINDOWS-1:0] win_start_hit,
   input  logic [NUM_WINDOWS-1:0] win_end_hit,
   input  logic [31:0]            mrac,              // Two bits per region
   output logic                   addr_in_dccm_d,
   output logic                   addr_in_pic_d,
   output logic                   addr_external_d,
   output logic                   access_fault_d,
   output logic                   misaligned_fault_d,
   output logic [2:0]             exc_mscause_d,
   output logic                   fir_dccm_access_error_d,
   output logic                   fir_nondccm_access_error_d,
   output logic                   is_sideeffects_m
);

   logic       start_addr_in_dccm_d, end_addr_in_dccm_d;
   logic       start_addr_in_dccm_region_d, end_addr_in_dccm_region_d;
   logic       start_addr_in_pic_d, end_addr_in_pic_d;
   logic       start_addr_in_pic_region_d, end_addr_in_pic_region_d;
   logic       addr_in_iccm, base_reg_dccm_or_pic, non_dccm_access_ok;
   logic       is_sideeffects_d, is_aligned_d;
   logic       unmapped_fault, mpu_fault, regpred_fault, picm_fault;
   logic       regcross_fault, sideeffect_fault;
   logic [2:0] access_mscause;
   logic [4:0] csr_idx;

   //**************************************************
   // Range checks
   //**************************************************
   if (DCCM_ENABLE) begin : g_dccm
      lsu_rangecheck #(.CCM_SADR(DCCM_SADR), .CCM_SIZE(DCCM_SIZE)) start_dccm_check (
         .addr      (start_addr_d),
         .in_range  (start_addr_in_dccm_d),
         .in_region (start_addr_in_dccm_region_d)
      );
      lsu_rangecheck #(.CCM_SADR(DCCM_SADR), .CCM_SIZE(DCCM_SIZE)) end_dccm_check (
         .addr      (end_addr_d),
         .in_range  (end_addr_in_dccm_d),
         .in_region (end_addr_in_dccm_region_d)
      );
   end else begin : g_no_dccm
      assign start_addr_in_dccm_d        = 1'b0;
      assign start_addr_in_dccm_region_d = 1'b0;
      assign end_addr_in_dccm_d          = 1'b0;
      assign end_addr_in_dccm_region_d   = 1'b0;
   end

   lsu_rangecheck #(.CCM_SADR(PIC_SADR), .CCM_SIZE(PIC_SIZE)) start_pic_check (
      .addr      (start_addr_d),
      .in_range  (start_addr_in_pic_d),
      .in_region (start_addr_in_pic_region_d)
   );
   lsu_rangecheck #(.CCM_SADR(PIC_SADR), .CCM_SIZE(PIC_SIZE)) end_pic_check (
      .addr      (end_addr_d),
      .in_range  (end_addr_in_pic_d),
      .in_region (end_addr_in_pic_region_d)
   );

   if (ICCM_ENABLE) begin : g_iccm
      assign addr_in_iccm = (start_addr_d[addr_w-1 -: region_w] == ICCM_REGION);
   end else begin : g_no_iccm
      assign addr_in_iccm = 1'b0;
   end

   //**************************************************
   // Classification
   //**************************************************
   assign addr_in_dccm_d  = start_addr_in_dccm_d & end_addr_in_dccm_d;
   assign addr_in_pic_d   = start_addr_in_pic_d & end_addr_in_pic_d;
   assign addr_external_d = ~(start_addr_in_dccm_region_d | start_addr_in_pic_region_d);
   assign base_reg_dccm_or_pic = (rs1_region_d == DCCM_REGION) | (rs1_region_d == PIC_REGION);

   // No window enabled means all external space is open
   assign non_dccm_access_ok = (WIN_ENABLE == '0) | ((|win_start_hit) & (|win_end_hit));

   assign csr_idx = {start_addr_d[addr_w-1 -: region_w], 1'b1};   // Side-effect bit of region
   assign is_sideeffects_d = mrac[csr_idx] & addr_external_d & ~addr_in_iccm &
                             valid_d & (load_d | store_d);
   assign is_aligned_d = ((size_d == size_word) & (start_addr_d[1:0] == 2'b00)) |
                         ((size_d == size_half) & ~start_addr_d[0]) |
                         (size_d == size_by);

   //**************************************************
   // Access faults
   //**************************************************
   assign regpred_fault = addr_external_d == base_reg_dccm_or_pic;   // Base and final disagree
   assign picm_fault    = addr_in_pic_d & ((start_addr_d[1:0] != 2'b00) | (size_d != size_word));

   if (DCCM_REGION == PIC_REGION) begin : g_shared_region
      assign unmapped_fault =
         (start_addr_in_dccm_region_d & ~(start_addr_in_dccm_d | start_addr_in_pic_d)) |
         (end_addr_in_dccm_region_d & ~(end_addr_in_dccm_d | end_addr_in_pic_d)) |
         (start_addr_in_dccm_d & end_addr_in_pic_d) |       // DCCM to PIC cross
         (start_addr_in_pic_d & end_addr_in_dccm_d);
      assign mpu_fault = ~start_addr_in_dccm_region_d & ~non_dccm_access_ok;
   end else begin : g_split_region
      assign unmapped_fault =
         (start_addr_in_dccm_region_d & ~start_addr_in_dccm_d) |
         (end_addr_in_dccm_region_d & ~end_addr_in_dccm_d) |
         (start_addr_in_pic_region_d & ~start_addr_in_pic_d) |
         (end_addr_in_pic_region_d & ~end_addr_in_pic_d);
      assign mpu_fault = addr_external_d & ~non_dccm_access_ok;
   end

   assign access_fault_d = (unmapped_fault | mpu_fault | regpred_fault | picm_fault) &
                           valid_d & ~dma_d;

   always_comb begin
      if (unmapped_fault)     access_mscause = mscause_unmapped;
      else if (mpu_fault)     access_mscause = mscause_mpu;
      else if (regpred_fault) access_mscause = mscause_regpred;
      else if (picm_fault)    access_mscause = mscause_picm;
      else                    access_mscause = mscause_none;
   end

   //**************************************************
   // Misaligned faults
   //**************************************************
   assign regcross_fault   = (start_addr_d[addr_w-1 -: region_w] != end_addr_d[addr_w-1 -: region_w]);
   assign sideeffect_fault = is_sideeffects_d & ~is_aligned_d;
   assign misaligned_fault_d = (regcross_fault | (sideeffect_fault & addr_external_d)) &
                               valid_d & ~dma_d;

   // Misaligned cause wins over access cause
   assign exc_mscause_d = ~misaligned_fault_d ? access_mscause :
                          regcross_fault      ? mscause_regcross : mscause_sideeffect;

   // Fast interrupt errors
   assign fir_dccm_access_error_d =
      ((start_addr_in_dccm_region_d & ~start_addr_in_dccm_d) |
       (end_addr_in_dccm_region_d & ~end_addr_in_dccm_d)) & valid_d & fast_int_d;
   assign fir_nondccm_access_error_d =
      ~(start_addr_in_dccm_region_d & end_addr_in_dccm_region_d) & valid_d & fast_int_d;

   always_ff @(posedge lsu_c2_m_clk or negedge rst_n) begin
      if (!rst_n) begin
         is_sideeffects_m <= 1'b0;
      end else begin
         is_sideeffects_m <= is_sideeffects_d;
      end
   end

   // Idle cycle is quiet now and in the M stage
   a_idle_quiet : assert property (@(posedge lsu_c2_m_clk) disable iff (!rst_n)
      !valid_d |-> !(access_fault_d | misaligned_fault_d | fir_dccm_access_error_d |
                     fir_nondccm_access_error_d) ##1 !is_sideeffects_m)
      else $error("lsu_addrcheck: activity without a valid request");

   a_fault_cause : assert property (@(posedge lsu_c2_m_clk) disable iff (!rst_n)
      access_fault_d |-> (exc_mscause_d != mscause_none))
      else $error("lsu_addrcheck: access fault without a cause");

endmodule

/* verilog/lsu_access_window.sv */
//**************************************************
// One data access window on the start and end address
// Set mask bits are don't care, a disabled window never hits
//**************************************************
module lsu_access_window
   import lsu_pkg::*;
#(
   parameter logic [addr_w-1:0] WIN_ADDR   = 32'h0,
   parameter logic [addr_w-1:0] WIN_MASK   = 32'hFFFF_FFFF,
   parameter bit                WIN_ENABLE = 1'b0
)(
   input  logic [addr_w-1:0] start_addr,
   input  logic [addr_w-1:0] end_addr,
   output logic              start_hit,
   output logic              end_hit
);

   localparam logic [addr_w-1:0] win_match = WIN_ADDR | WIN_MASK;

   assign start_hit = WIN_ENABLE && ((start_addr | WIN_MASK) == win_match);
   assign end_hit   = WIN_ENABLE && ((end_addr   | WIN_MASK) == win_match);

endmodule

/* verilog/lsu_agen.sv */
//**************************************************
// Address generation, one register stage
// Size code 3 must not be sent with lsu_valid
//**************************************************
module lsu_agen
   import lsu_pkg::*;
(
   input  logic                lsu_c2_m_clk,
   input  logic                rst_n,
   input  logic                lsu_valid,
   input  logic [addr_w-1:0]   rs1,
   input  logic signed [11:0]  offset,
   input  logic [1:0]          size,
   input  logic                load,
   input  logic                store,
   input  logic                dma,
   input  logic                fast_int,
   output logic [addr_w-1:0]   start_addr_d,
   output logic [addr_w-1:0]   end_addr_d,
   output logic [region_w-1:0] rs1_region_d,
   output logic                valid_d,
   output logic [1:0]          size_d,
   output logic                load_d,
   output logic                store_d,
   output logic                dma_d,
   output logic                fast_int_d
);

   logic [addr_w-1:0] start_addr;
   logic [addr_w-1:0] end_addr;
   logic [1:0]        end_off;        // Byte count minus one

   assign start_addr = rs1 + {{(addr_w-12){offset[11]}}, offset};

   always_comb begin
      case (size)
         size_half: end_off = 2'd1;
         size_word: end_off = 2'd3;
         default:   end_off = 2'd0;
      endcase
   end

   assign end_addr = start_addr + {{(addr_w-2){1'b0}}, end_off};

   always_ff @(posedge lsu_c2_m_clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_d <= 1'b0;
      end else begin
         valid_d <= lsu_valid;
      end
   end

   // Request payload, qualified by valid_d downstream
   always_ff @(posedge lsu_c2_m_clk) begin
      start_addr_d <= start_addr;
      end_addr_d   <= end_addr;
      rs1_region_d <= rs1[addr_w-1 -: region_w];
      size_d       <= size;
      load_d       <= load;
      store_d      <= store;
      dma_d        <= dma;
      fast_int_d   <= fast_int;
   end

   a_size_legal : assert property (@(posedge lsu_c2_m_clk) disable iff (!rst_n)
      lsu_valid |-> (size != 2'd3))
      else $error("lsu_agen: illegal access size with lsu_valid");

endmodule

/* verilog/lsu_rangecheck.sv */
//**************************************************
// One address against one base and size
// Base must be aligned to the size, size a power of two
//**************************************************
module lsu_rangecheck
   import lsu_pkg::*;
#(
   parameter logic [addr_w-1:0] CCM_SADR = 32'h0,
   parameter int unsigned       CCM_SIZE = 32'h1000
)(
   input  logic [addr_w-1:0] addr,
   output logic              in_range,
   output logic              in_region
);

   localparam int size_lsb = $clog2(CCM_SIZE);

   if ((CCM_SIZE == 0) || ((CCM_SIZE & (CCM_SIZE - 1)) != 0)) begin : g_bad_size
      $error("lsu_rangecheck: CCM_SIZE %0h is not a power of two", CCM_SIZE);
   end

   assign in_region = (addr[addr_w-1 -: region_w] == CCM_SADR[addr_w-1 -: region_w]);

   // Offset bits below the size are ignored
   assign in_range  = (addr[addr_w-1:size_lsb] == CCM_SADR[addr_w-1:size_lsb]);

endmodule

/* verilog/lsu_pkg.sv */
//**************************************************
// Shared widths, size codes and mscause codes
// Default memory map comes from lsu_memmap.svh
//**************************************************
package lsu_pkg;

`include "lsu_memmap.svh"

   localparam int addr_w   = 32;
   localparam int region_w = 4;            // Top address nibble

   // Access size
   localparam logic [1:0] size_by   = 2'd0;
   localparam logic [1:0] size_half = 2'd1;
   localparam logic [1:0] size_word = 2'd2;   // Code 3 is illegal

   // Access fault causes
   localparam logic [2:0] mscause_unmapped = 3'd0;
   localparam logic [2:0] mscause_mpu      = 3'd3;
   localparam logic [2:0] mscause_regpred  = 3'd5;
   localparam logic [2:0] mscause_picm     = 3'd6;
   localparam logic [2:0] mscause_none     = 3'd7;

   // Misaligned causes
   localparam logic [2:0] mscause_regcross   = 3'd0;
   localparam logic [2:0] mscause_sideeffect = 3'd1;

   //**************************************************
   // Default memory map
   //**************************************************
   localparam bit                  dccm_enable_dflt = `LSU_DCCM_ENABLE;
   localparam logic [addr_w-1:0]   dccm_sadr_dflt   = `LSU_DCCM_SADR;
   localparam int unsigned         dccm_size_dflt   = `LSU_DCCM_SIZE;
   localparam logic [region_w-1:0] dccm_region_dflt = `LSU_DCCM_REGION;
   localparam logic [addr_w-1:0]   pic_sadr_dflt    = `LSU_PIC_SADR;
   localparam int unsigned         pic_size_dflt    = `LSU_PIC_SIZE;
   localparam logic [region_w-1:0] pic_region_dflt  = `LSU_PIC_REGION;
   localparam bit                  iccm_enable_dflt = `LSU_ICCM_ENABLE;
   localparam logic [region_w-1:0] iccm_region_dflt = `LSU_ICCM_REGION;

   localparam int num_windows_dflt = 4;
   localparam logic [3:0][addr_w-1:0] win_addr_dflt =
      {`LSU_WIN3_ADDR, `LSU_WIN2_ADDR, `LSU_WIN1_ADDR, `LSU_WIN0_ADDR};
   localparam logic [3:0][addr_w-1:0] win_mask_dflt =
      {`LSU_WIN3_MASK, `LSU_WIN2_MASK, `LSU_WIN1_MASK, `LSU_WIN0_MASK};
   localparam logic [3:0] win_enable_dflt = `LSU_WIN_ENABLE;

endpackage

/* include/lsu_memmap.svh */
//**************************************************
// Default memory map for the load/store address check
// DCCM and PIC share region 0xF, sizes are powers of two
//**************************************************
`ifndef LSU_MEMMAP_SVH
`define LSU_MEMMAP_SVH

// DCCM
`define LSU_DCCM_ENABLE   1'b1
`define LSU_DCCM_REGION   4'hF
`define LSU_DCCM_SADR     32'hF004_0000
`define LSU_DCCM_SIZE     32'h0001_0000   // 64 KB

// PIC memory-mapped registers
`define LSU_PIC_REGION    4'hF
`define LSU_PIC_SADR      32'hF00C_0000
`define LSU_PIC_SIZE      32'h0000_8000   // 32 KB

// ICCM, only the region is checked here
`define LSU_ICCM_ENABLE   1'b1
`define LSU_ICCM_REGION   4'hE

// Data access windows, mask bits are don't care
`define LSU_WIN0_ADDR     32'h0000_0000
`define LSU_WIN0_MASK     32'h0FFF_FFFF   // Whole region 0
`define LSU_WIN1_ADDR     32'hA000_0000
`define LSU_WIN1_MASK     32'h000F_FFFF   // 1 MB
`define LSU_WIN2_ADDR     32'hC000_0000
`define LSU_WIN2_MASK     32'h0FFF_FFFF
`define LSU_WIN3_ADDR     32'h8000_0000
`define LSU_WIN3_MASK     32'h00FF_FFFF
`define LSU_WIN_ENABLE    4'b0011         // Windows 0 and 1 only

`endif
